//--- rtl/io_bridge_pkg.sv
`default_nettype none

package io_bridge_pkg;

  // ============================================================
  // Datapath sizes
  // ============================================================
  localparam int byte_w      = 8;
  localparam int block_w     = 128;
  localparam int block_bytes = 16;
  localparam int index_w     = 4;

  // ============================================================
  // Host interface codes
  // ============================================================

  // Codes on to_hw_sig, meaning depends on the current phase
  typedef enum logic [1:0] {
    HOST_IDLE  = 2'd0,
    HOST_STEP  = 2'd1,
    HOST_ACK   = 2'd2,
    HOST_START = 2'd3
  } host_cmd_e;

  // Codes on to_sw_sig
  typedef enum logic [1:0] {
    SW_IDLE   = 2'd0,
    SW_STROBE = 2'd1,
    SW_BUSY   = 2'd2,
    SW_RESET  = 2'd3
  } bridge_status_e;

  // Sequencer phases
  typedef enum logic [2:0] {
    ST_RESET,
    ST_WAIT,
    ST_RECV,
    ST_RECV_ACK,
    ST_START,
    ST_AWAIT,
    ST_SEND,
    ST_SEND_ACK
  } bridge_state_e;

endpackage

`default_nettype wire

//--- rtl/io_handshake_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module io_handshake_fsm
  import io_bridge_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 reset_n,
  input  wire host_cmd_e            to_hw_sig,
  input  wire logic                 aes_ready,
  output bridge_status_e            to_sw_sig,
  output logic                      io_ready,
  output logic                      load_msg,
  output logic                      load_key,
  output logic                      send_load,
  output logic [index_w-1:0]        byte_index
);

  bridge_state_e        state;
  bridge_state_e        next_state;
  logic                 is_key;
  logic [index_w-1:0]   count;
  logic                 step_acked;
  logic                 last_done;

  // Host acknowledged the byte of the current strobe step
  assign step_acked = (state == ST_RECV || state == ST_SEND) && (to_hw_sig == HOST_ACK);

  // Counter wraps back to zero once all sixteen bytes are acknowledged
  assign last_done = (count == '0);

  // ============================================================
  // Phase register, target flag and byte counter
  // ============================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= ST_RESET;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      is_key <= 1'b0;
    end else if (state == ST_WAIT) begin
      // Step selects the message, ack selects the key
      if (to_hw_sig == HOST_STEP) begin
        is_key <= 1'b0;
      end else if (to_hw_sig == HOST_ACK) begin
        is_key <= 1'b1;
      end
    end
  end

  // Advances on each ack so it already points at the next byte
  // during the ack phase
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      count <= '0;
    end else if (state == ST_WAIT) begin
      count <= '0;
    end else if (step_acked) begin
      count <= count + 1'b1;
    end
  end

  // ============================================================
  // Next phase
  // ============================================================
  always_comb begin
    next_state = state;
    unique case (state)
      ST_RESET: begin
        next_state = ST_WAIT;
      end
      ST_WAIT: begin
        if (to_hw_sig == HOST_STEP || to_hw_sig == HOST_ACK) begin
          next_state = ST_RECV;
        end else if (to_hw_sig == HOST_START) begin
          next_state = ST_START;
        end
      end
      ST_RECV: begin
        if (to_hw_sig == HOST_ACK) begin
          next_state = ST_RECV_ACK;
        end
      end
      ST_RECV_ACK: begin
        if (to_hw_sig == HOST_STEP) begin
          next_state = last_done ? ST_WAIT : ST_RECV;
        end
      end
      ST_START: begin
        next_state = ST_AWAIT;
      end
      ST_AWAIT: begin
        if (aes_ready) begin
          next_state = ST_SEND;
        end
      end
      ST_SEND: begin
        if (to_hw_sig == HOST_ACK) begin
          next_state = ST_SEND_ACK;
        end
      end
      ST_SEND_ACK: begin
        if (to_hw_sig == HOST_STEP) begin
          next_state = last_done ? ST_WAIT : ST_SEND;
        end
      end
      default: begin
        next_state = ST_RESET;
      end
    endcase
  end

  // ============================================================
  // Outputs
  // ============================================================
  always_comb begin
    to_sw_sig = SW_IDLE;
    unique case (state)
      ST_RESET: begin
        to_sw_sig = SW_RESET;
      end
      ST_RECV, ST_SEND: begin
        to_sw_sig = SW_STROBE;
      end
      ST_AWAIT: begin
        to_sw_sig = SW_BUSY;
      end
      default: begin
        to_sw_sig = SW_IDLE;
      end
    endcase
  end

  assign io_ready = (state == ST_START);

  // Loader writes every cycle of a receive step
  assign load_msg = (state == ST_RECV) && !is_key;
  assign load_key = (state == ST_RECV) && is_key;

  // Fires on the edge that enters a send step, so the byte is
  // in place by the time the strobe is shown
  assign send_load = (next_state == ST_SEND) && (state != ST_SEND);

  assign byte_index = count;

endmodule

`default_nettype wire

//--- rtl/block_loader.sv
`timescale 1ns/1ps
`default_nettype none

module block_loader
  import io_bridge_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 reset_n,
  input  wire logic [byte_w-1:0]    to_hw_port,
  input  wire logic                 load_msg,
  input  wire logic                 load_key,
  input  wire logic [index_w-1:0]   byte_index,
  output logic      [block_w-1:0]   msg_en,
  output logic      [block_w-1:0]   key
);

  logic [index_w-1:0] lane;

  // Byte 0 is the most significant, so it lands in the top lane
  assign lane = index_w'(block_bytes - 1) - byte_index;

  // ============================================================
  // Message register
  // ============================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      msg_en <= '0;
    end else if (load_msg) begin
      msg_en[lane*byte_w +: byte_w] <= to_hw_port;
    end
  end

  // ============================================================
  // Key register
  // ============================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key <= '0;
    end else if (load_key) begin
      key[lane*byte_w +: byte_w] <= to_hw_port;
    end
  end

endmodule

`default_nettype wire

//--- rtl/block_unloader.sv
`timescale 1ns/1ps
`default_nettype none

module block_unloader
  import io_bridge_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 reset_n,
  input  wire logic [block_w-1:0]   msg_de,
  input  wire logic                 send_load,
  input  wire logic [index_w-1:0]   byte_index,
  output logic      [byte_w-1:0]    to_sw_port
);

  logic [index_w-1:0] lane;

  // Same MSB-first ordering as the loader
  assign lane = index_w'(block_bytes - 1) - byte_index;

  // Captured once per send step and held while the strobe is up
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      to_sw_port <= '0;
    end else if (send_load) begin
      to_sw_port <= msg_de[lane*byte_w +: byte_w];
    end
  end

endmodule

`default_nettype wire

//--- rtl/io_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module io_bridge
  import io_bridge_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 reset_n,

  // Host side
  input  wire host_cmd_e            to_hw_sig,
  input  wire logic [byte_w-1:0]    to_hw_port,
  output bridge_status_e            to_sw_sig,
  output logic      [byte_w-1:0]    to_sw_port,

  // Cipher side
  output logic      [block_w-1:0]   msg_en,
  output logic      [block_w-1:0]   key,
  input  wire logic [block_w-1:0]   msg_de,
  output logic                      io_ready,
  input  wire logic                 aes_ready
);

  logic                 load_msg;
  logic                 load_key;
  logic                 send_load;
  logic [index_w-1:0]   byte_index;

  // ============================================================
  // Sequencer
  // ============================================================
  io_handshake_fsm i_io_handshake_fsm (
    .clk        (clk),
    .reset_n    (reset_n),
    .to_hw_sig  (to_hw_sig),
    .aes_ready  (aes_ready),
    .to_sw_sig  (to_sw_sig),
    .io_ready   (io_ready),
    .load_msg   (load_msg),
    .load_key   (load_key),
    .send_load  (send_load),
    .byte_index (byte_index)
  );

  // ============================================================
  // Datapath
  // ============================================================

  // Host bytes into message and key
  block_loader i_block_loader (
    .clk        (clk),
    .reset_n    (reset_n),
    .to_hw_port (to_hw_port),
    .load_msg   (load_msg),
    .load_key   (load_key),
    .byte_index (byte_index),
    .msg_en     (msg_en),
    .key        (key)
  );

  // Cipher result back to the host
  block_unloader i_block_unloader (
    .clk        (clk),
    .reset_n    (reset_n),
    .msg_de     (msg_de),
    .send_load  (send_load),
    .byte_index (byte_index),
    .to_sw_port (to_sw_port)
  );

endmodule

`default_nettype wire

//--- test/io_bridge_props.sv
`timescale 1ns/1ps
`default_nettype none

module io_bridge_props
  import io_bridge_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 reset_n,
  input  wire logic                 io_ready,
  input  wire bridge_status_e       to_sw_sig
);

  // Count of failed assertions
  int   fail_count = 0;
  logic seen_idle;

  // Set once the bridge has left the reset status
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      seen_idle <= 1'b0;
    end else if (to_sw_sig == SW_IDLE) begin
      seen_idle <= 1'b1;
    end
  end

  // ============================================================
  // Start pulse
  // ============================================================
  single_start_pulse: assert property (
    @(posedge clk) disable iff (!reset_n) io_ready |=> !io_ready
  ) else begin
    fail_count++;
    $error("io_ready high on two consecutive cycles");
  end

  busy_after_start: assert property (
    @(posedge clk) disable iff (!reset_n) io_ready |=> (to_sw_sig == SW_BUSY)
  ) else begin
    fail_count++;
    $error("io_ready pulse not followed by the busy status");
  end

  // Reset status only shows up once per reset
  no_late_reset_status: assert property (
    @(posedge clk) disable iff (!reset_n) seen_idle |-> (to_sw_sig != SW_RESET)
  ) else begin
    fail_count++;
    $error("reset status shown again after the bridge went idle");
  end

endmodule

bind io_bridge io_bridge_props i_io_bridge_props (
  .clk       (clk),
  .reset_n   (reset_n),
  .io_ready  (io_ready),
  .to_sw_sig (to_sw_sig)
);

`default_nettype wire

//--- test/io_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module io_bridge_tb
  import io_bridge_pkg::*;
();

  // Four rounds of roughly 330 cycles, plus margin
  localparam int num_rounds = 4;
  localparam int max_cycles = num_rounds * 330 + 680;

  logic                 clk;
  logic                 reset_n;
  host_cmd_e            to_hw_sig;
  logic [byte_w-1:0]    to_hw_port;
  bridge_status_e       to_sw_sig;
  logic [byte_w-1:0]    to_sw_port;
  logic [block_w-1:0]   msg_en;
  logic [block_w-1:0]   key;
  logic [block_w-1:0]   msg_de;
  logic                 io_ready;
  logic                 aes_ready;

  integer               seed = 54;
  int                   errors = 0;
  int                   checks = 0;
  int                   cycles = 0;
  string                test_name = "reset";
  logic [block_w-1:0]   exp_msg = '0;
  logic [block_w-1:0]   exp_key = '0;
  logic [block_w-1:0]   exp_res = '0;
  logic                 reading = 1'b0;
  int                   rd_count = 0;
  bridge_status_e       prev_status = SW_RESET;
  logic                 prev_aes_ready = 1'b0;

  io_bridge i_io_bridge (
    .clk        (clk),
    .reset_n    (reset_n),
    .to_hw_sig  (to_hw_sig),
    .to_hw_port (to_hw_port),
    .to_sw_sig  (to_sw_sig),
    .to_sw_port (to_sw_port),
    .msg_en     (msg_en),
    .key        (key),
    .msg_de     (msg_de),
    .io_ready   (io_ready),
    .aes_ready  (aes_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ============================================================
  // Reference model and helpers
  // ============================================================

  // Stand-in cipher: message XOR key, byte-reversed
  function automatic logic [block_w-1:0] cipher_ref(input logic [block_w-1:0] m,
                                                    input logic [block_w-1:0] k);
    logic [block_w-1:0] x;
    logic [block_w-1:0] r;
    x = m ^ k;
    for (int i = 0; i < block_bytes; i++) begin
      r[i*byte_w +: byte_w] = x[(block_bytes-1-i)*byte_w +: byte_w];
    end
    return r;
  endfunction

  function automatic logic [block_w-1:0] random_block();
    logic [block_w-1:0] v;
    v = '0;
    for (int i = 0; i < 4; i++) begin
      v = {v[block_w-33:0], $random(seed)};
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [block_w-1:0] expected,
                             input logic [block_w-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("[FAIL] %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  // Host acts 1 ns after each rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_status(input bridge_status_e want);
    while (to_sw_sig !== want) begin
      tick();
    end
  endtask

  // Strobe, ack, idle, step: one byte of either direction
  task automatic handshake_byte();
    wait_status(SW_STROBE);
    to_hw_sig = HOST_ACK;
    tick();
    wait_status(SW_IDLE);
    to_hw_sig = HOST_STEP;
    tick();
    to_hw_sig = HOST_IDLE;
  endtask

  task automatic load_block(input logic is_key, input logic [block_w-1:0] value);
    wait_status(SW_IDLE);
    to_hw_sig = is_key ? HOST_ACK : HOST_STEP;
    tick();
    to_hw_sig = HOST_IDLE;
    for (int i = 0; i < block_bytes; i++) begin
      wait_status(SW_STROBE);
      to_hw_port = value[(block_bytes-1-i)*byte_w +: byte_w];
      handshake_byte();
    end
    tick();
    check_value("status after load", SW_IDLE, to_sw_sig);
  endtask

  task automatic start_cipher();
    wait_status(SW_IDLE);
    to_hw_sig = HOST_START;
    tick();
    to_hw_sig = HOST_IDLE;
    check_value("io_ready pulse", 1'b1, io_ready);
    tick();
    check_value("io_ready after pulse", 1'b0, io_ready);
    check_value("status after start", SW_BUSY, to_sw_sig);
    wait_status(SW_STROBE);
  endtask

  task automatic read_result();
    exp_res = cipher_ref(exp_msg, exp_key);
    rd_count = 0;
    reading = 1'b1;
    for (int i = 0; i < block_bytes; i++) begin
      handshake_byte();
    end
    tick();
    reading = 1'b0;
    check_value("result bytes strobed", block_bytes, rd_count);
    check_value("status after read-back", SW_IDLE, to_sw_sig);
  endtask

  task automatic run_round(input int round, input logic [block_w-1:0] m,
                           input logic [block_w-1:0] k);
    test_name = $sformatf("round%0d_msg_load", round);
    load_block(1'b0, m);
    exp_msg = m;
    check_value("msg_en", exp_msg, msg_en);
    check_value("key unchanged", exp_key, key);
    test_name = $sformatf("round%0d_key_load", round);
    load_block(1'b1, k);
    exp_key = k;
    check_value("key", exp_key, key);
    check_value("msg_en unchanged", exp_msg, msg_en);
    test_name = $sformatf("round%0d_start", round);
    start_cipher();
    test_name = $sformatf("round%0d_readback", round);
    read_result();
  endtask

  // ============================================================
  // Cipher core model
  // ============================================================
  initial begin
    int                 delay;
    logic [block_w-1:0] result;
    forever begin
      tick();
      if (io_ready === 1'b1) begin
        result = cipher_ref(msg_en, key);
        delay = 1 + int'($unsigned($random(seed)) % 12);
        repeat (delay) tick();
        msg_de = result;
        aes_ready = 1'b1;
        while (to_sw_sig === SW_BUSY) begin
          tick();
        end
        aes_ready = 1'b0;
      end
    end
  end

  // ============================================================
  // Comparison at the falling edge, where everything is settled
  // ============================================================
  always @(negedge clk) begin
    if (reset_n) begin
      if (to_sw_sig === SW_BUSY) begin
        checks++;
        assert (!prev_aes_ready) else begin
          errors++;
          $display("%s: bridge stayed busy after aes_ready was raised", test_name);
        end
      end
      if (prev_status === SW_BUSY && to_sw_sig !== SW_BUSY) begin
        checks++;
        assert (prev_aes_ready) else begin
          errors++;
          $display("%s: bridge left the busy state without aes_ready", test_name);
        end
      end
      if (reading && to_sw_sig === SW_STROBE) begin
        assert (rd_count < block_bytes) else begin
          errors++;
          $display("%s: more than sixteen result bytes strobed", test_name);
        end
        if (rd_count < block_bytes) begin
          check_value($sformatf("result byte %0d", rd_count),
                      exp_res[(block_bytes-1-rd_count)*byte_w +: byte_w], to_sw_port);
        end
      end
      // Strobe dropping marks the end of one byte
      if (reading && prev_status === SW_STROBE && to_sw_sig !== SW_STROBE) begin
        rd_count++;
      end
      prev_status = to_sw_sig;
      prev_aes_ready = aes_ready;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > max_cycles) begin
      $display("Timeout: the run did not complete within %0d cycles", max_cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    logic [block_w-1:0] new_msg;
    logic [block_w-1:0] new_key;
    reset_n = 1'b0;
    to_hw_sig = HOST_IDLE;
    to_hw_port = '0;
    msg_de = '0;
    aes_ready = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;
    check_value("status after release", SW_RESET, to_sw_sig);
    check_value("io_ready", 1'b0, io_ready);
    check_value("msg_en", '0, msg_en);
    check_value("key", '0, key);
    check_value("to_sw_port", '0, to_sw_port);
    tick();
    check_value("status one cycle later", SW_IDLE, to_sw_sig);
    for (int r = 0; r < num_rounds; r++) begin
      if (r == 0) begin
        new_msg = 128'h00112233445566778899aabbccddeeff;
        new_key = 128'h0f1e2d3c4b5a69788796a5b4c3d2e1f0;
      end else begin
        new_msg = random_block();
        new_key = random_block();
      end
      run_round(r, new_msg, new_key);
    end
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, i_io_bridge.i_io_bridge_props.fail_count);
    if (errors == 0 && i_io_bridge.i_io_bridge_props.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
rtl/io_bridge_pkg.sv
rtl/io_handshake_fsm.sv
rtl/block_loader.sv
rtl/block_unloader.sv
rtl/io_bridge.sv
test/io_bridge_props.sv
test/io_bridge_tb.sv

//--- Makefile
# Verilator simulation of the host bridge

VERILATOR ?= verilator
TOP       ?= io_bridge_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
